/* files.f */
hdl/alu_pkg.sv
hdl/alu_lane.sv
hdl/mul_unit.sv
hdl/div_unit.sv
hdl/alu_top.sv
test/alu_top_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= alu_top_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := TEST FAILED
PASS_MSG  := TEST PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "No result found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/alu_vectors.txt */
# op1 a1 b1 hilo_write1 exp1 op2 a2 b2 hilo_write2 exp2 m_ena m_flush
# then expected y1 overflow1 y2 overflow2, every field in hex
0f 00000000 00000000 0 0 10 00000000 00000000 0 0 1 0 00000000 0 00000000 0
01 7fffffff 00000001 0 0 02 ffffffff 00000002 0 0 1 0 80000000 1 00000001 0
03 80000000 00000001 0 0 04 00000000 00000001 0 0 1 0 7fffffff 1 ffffffff 0
05 f0f0f0f0 ff00ff00 0 0 08 0f0f0000 000000ff 0 0 1 0 f000f000 0 f0f0ff00 0
09 ffffffff 00000001 0 0 0a ffffffff 00000001 0 0 1 0 00000001 0 00000000 0
0b 00000001 00000024 0 0 0c 80000000 0000001f 0 0 1 0 00000010 0 00000001 0
0d 80000000 00000004 0 0 0e 00000000 0000abcd 0 0 1 0 f8000000 0 abcd0000 0
13 fffffffe 00000003 1 0 00 00000000 00000000 0 0 1 0 00000000 0 00000000 0
0f 00000000 00000000 0 0 10 00000000 00000000 0 0 1 0 ffffffff 0 fffffffa 0
00 00000000 00000000 0 0 14 ffffffff ffffffff 1 0 1 0 00000000 0 00000000 0
10 00000000 00000000 0 0 0f 00000000 00000000 0 0 1 0 00000001 0 fffffffe 0
15 fffffff9 00000002 1 0 00 00000000 00000000 0 0 1 0 00000000 0 00000000 0
0f 00000000 00000000 0 0 10 00000000 00000000 0 0 1 0 ffffffff 0 fffffffd 0
00 00000000 00000000 0 0 16 ffffffff 00000010 1 0 1 0 00000000 0 00000000 0
0f 00000000 00000000 0 0 10 00000000 00000000 0 0 1 0 0000000f 0 0fffffff 0
11 11111111 00000000 1 0 02 00000001 00000001 0 0 1 0 00000000 0 00000002 0
11 22222222 00000000 1 0 12 33333333 00000000 1 0 1 0 00000000 0 00000000 0
0f 00000000 00000000 0 0 10 00000000 00000000 0 0 1 0 11111111 0 33333333 0
11 44444444 00000000 1 0 00 00000000 00000000 0 0 0 0 00000000 0 00000000 0
00 00000000 00000000 0 0 12 55555555 00000000 1 0 1 1 00000000 0 00000000 0
11 66666666 00000000 1 1 12 77777777 00000000 1 0 1 0 00000000 0 00000000 0
00 00000000 00000000 0 0 12 88888888 00000000 1 1 1 0 00000000 0 00000000 0
0f 00000000 00000000 0 0 10 00000000 00000000 0 0 1 0 11111111 0 33333333 0

/* test/alu_top_tb.sv */
`default_nettype none
`timescale 1ns/10ps

module alu_top_tb import alu_pkg::*; ();

    localparam int half_period   = 10;          // 20 ns clock
    localparam int stall_timeout = 60;          // Cycles
    localparam int max_steps     = 200;
    localparam int random_steps  = 16;

    logic    clk, reset_i, m_ena_i, m_flush_i;
    logic    hilo_write1_i, exp1_i, hilo_write2_i, exp2_i;
    alu_op_e aluop1_i, aluop2_i;
    word_t   a1_i, b1_i, a2_i, b2_i, y1_o, y2_o;
    logic    overflow1_o, overflow2_o, alu_stall_o;
    integer  seed;
    integer  step_no;

    alu_top alu_top_i (
        .clk           ( clk           ),
        .reset_i       ( reset_i       ),
        .m_ena_i       ( m_ena_i       ),
        .m_flush_i     ( m_flush_i     ),
        .hilo_write1_i ( hilo_write1_i ),
        .exp1_i        ( exp1_i        ),
        .aluop1_i      ( aluop1_i      ),
        .a1_i          ( a1_i          ),
        .b1_i          ( b1_i          ),
        .y1_o          ( y1_o          ),
        .overflow1_o   ( overflow1_o   ),
        .hilo_write2_i ( hilo_write2_i ),
        .exp2_i        ( exp2_i        ),
        .aluop2_i      ( aluop2_i      ),
        .a2_i          ( a2_i          ),
        .b2_i          ( b2_i          ),
        .y2_o          ( y2_o          ),
        .overflow2_o   ( overflow2_o   ),
        .alu_stall_o   ( alu_stall_o   )
    );

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        assert (actual === expected) else
            report_failure($sformatf("mismatch %s at step %0d expected %h actual %h",
                                     name, step_no, expected, actual));
    endtask

    task automatic drive_inputs(input logic [7:0] op1, input word_t a1, input word_t b1,
                                input logic hw1, input logic ex1,
                                input logic [7:0] op2, input word_t a2, input word_t b2,
                                input logic hw2, input logic ex2,
                                input logic ena, input logic flush);
        @(posedge clk);
        #2;
        aluop1_i      = alu_op_e'(op1);
        a1_i          = a1;
        b1_i          = b1;
        hilo_write1_i = hw1;
        exp1_i        = ex1;
        aluop2_i      = alu_op_e'(op2);
        a2_i          = a2;
        b2_i          = b2;
        hilo_write2_i = hw2;
        exp2_i        = ex2;
        m_ena_i       = ena;
        m_flush_i     = flush;
    endtask

    // Samples mid-cycle and lets the next edge end the step
    task automatic finish_step(input word_t ey1, input logic eov1,
                               input word_t ey2, input logic eov2, input int estall);
        integer waited;
        waited = 0;
        #8;
        while (alu_stall_o) begin
            @(posedge clk);
            #10;
            waited = waited + 1;
            if (waited >= stall_timeout)
                report_failure($sformatf("stall never cleared at step %0d", step_no));
        end
        check_value("alu_stall_o cycles", word_t'(estall), word_t'(waited));
        check_value("y1_o", ey1, y1_o);
        check_value("overflow1_o", {31'b0, eov1}, {31'b0, overflow1_o});
        check_value("y2_o", ey2, y2_o);
        check_value("overflow2_o", {31'b0, eov2}, {31'b0, overflow2_o});
    endtask

    // Cycles of stall a step should see before its ready cycle
    function automatic int stall_cycles(input logic [7:0] op1, input logic [7:0] op2);
        stall_cycles = 0;
        if (op1 inside {alu_mult, alu_multu} || op2 inside {alu_mult, alu_multu})
            stall_cycles = mul_latency;
        if (op1 inside {alu_div, alu_divu} || op2 inside {alu_div, alu_divu})
            stall_cycles = div_latency;
    endfunction

    function automatic alu_op_e logic_op(input logic [1:0] sel);
        case (sel)
            2'd0:    logic_op = alu_and;
            2'd1:    logic_op = alu_or;
            2'd2:    logic_op = alu_xor;
            default: logic_op = alu_nor;
        endcase
    endfunction

    function automatic word_t logic_expected(input alu_op_e op, input word_t a, input word_t b);
        case (op)
            alu_and: logic_expected = a & b;
            alu_or:  logic_expected = a | b;
            alu_xor: logic_expected = (a | b) & ~(a & b);
            default: logic_expected = ~a & ~b;
        endcase
    endfunction

    initial begin
        string       line;
        integer      fd, got, n, i;
        logic [7:0]  v_op1, v_op2;
        word_t       v_a1, v_b1, v_a2, v_b2, v_y1, v_y2;
        logic        v_hw1, v_ex1, v_hw2, v_ex2, v_ena, v_flush, v_ov1, v_ov2;
        logic [31:0] r;
        alu_op_e     op1, op2;
        word_t       a1, b1, a2, b2;

        seed    = 32'h9da4;
        step_no = 0;
        reset_i = 1'b1;
        drive_defaults();
        repeat (3) @(posedge clk);
        #2 reset_i = 1'b0;
        #8 check_value("alu_stall_o", 32'h0, {31'b0, alu_stall_o});

        fd = $fopen("test/alu_vectors.txt", "r");
        if (fd == 0)
            report_failure("could not open test/alu_vectors.txt");
        while (!$feof(fd)) begin
            line = "";
            got  = $fgets(line, fd);
            n    = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                           v_op1, v_a1, v_b1, v_hw1, v_ex1, v_op2, v_a2, v_b2, v_hw2,
                           v_ex2, v_ena, v_flush, v_y1, v_ov1, v_y2, v_ov2);
            if (got != 0 && n == 16) begin
                step_no = step_no + 1;
                if (step_no > max_steps)
                    report_failure("vectors file holds more steps than allowed");
                drive_inputs(v_op1, v_a1, v_b1, v_hw1, v_ex1, v_op2, v_a2, v_b2,
                             v_hw2, v_ex2, v_ena, v_flush);
                finish_step(v_y1, v_ov1, v_y2, v_ov2, stall_cycles(v_op1, v_op2));
            end else if (got != 0 && n > 0) begin
                report_failure($sformatf("malformed line after step %0d", step_no));
            end
        end
        $fclose(fd);
        if (step_no == 0)
            report_failure("no vectors were read");

        for (i = 0; i < random_steps; i++) begin  // Logic ops on random operands
            r  = $random(seed);
            op1 = logic_op(r[1:0]);
            op2 = logic_op(r[3:2]);
            a1 = $random(seed);
            b1 = $random(seed);
            a2 = $random(seed);
            b2 = $random(seed);
            step_no = step_no + 1;
            drive_inputs(op1, a1, b1, 1'b0, 1'b0, op2, a2, b2, 1'b0, 1'b0, 1'b1, 1'b0);
            finish_step(logic_expected(op1, a1, b1), 1'b0,
                        logic_expected(op2, a2, b2), 1'b0, 0);
        end

        $display("TEST PASSED");
        $finish;
    end

    task automatic drive_defaults();
        aluop1_i      = alu_nop;
        aluop2_i      = alu_nop;
        a1_i          = '0;
        b1_i          = '0;
        a2_i          = '0;
        b2_i          = '0;
        hilo_write1_i = 1'b0;
        hilo_write2_i = 1'b0;
        exp1_i        = 1'b0;
        exp2_i        = 1'b0;
        m_ena_i       = 1'b0;
        m_flush_i     = 1'b0;
    endtask

endmodule

`default_nettype wire

/* hdl/alu_top.sv */
`default_nettype none
`timescale 1ns/10ps

module alu_top import alu_pkg::*; (
    input  logic    clk,
    input  logic    reset_i,

    input  logic    m_ena_i,
    input  logic    m_flush_i,

    input  logic    hilo_write1_i,
    input  logic    exp1_i,
    input  alu_op_e aluop1_i,
    input  word_t   a1_i,
    input  word_t   b1_i,
    output word_t   y1_o,
    output logic    overflow1_o,

    input  logic    hilo_write2_i,
    input  logic    exp2_i,
    input  alu_op_e aluop2_i,
    input  word_t   a2_i,
    input  word_t   b2_i,
    output word_t   y2_o,
    output logic    overflow2_o,

    output logic    alu_stall_o
);

    logic   mul_req1, mul_signed1, div_req1, div_signed1;
    logic   mul_req2, mul_signed2, div_req2, div_signed2;
    logic   mul_start, mul_sign, mul_ready;
    logic   div_start, div_sign, div_ready;
    word_t  mul_a, mul_b, div_a, div_b;
    dword_t mul_result, div_result;
    dword_t hilo_q, hilo_wdata, hilo_wdata1, hilo_wdata2;
    logic   hilo_wen;

    alu_lane u_lane_a (
        .clk          ( clk          ),
        .reset_i      ( reset_i      ),
        .aluop_i      ( aluop1_i     ),
        .a_i          ( a1_i         ),
        .b_i          ( b1_i         ),
        .hilo_i       ( hilo_q       ),
        .y_o          ( y1_o         ),
        .overflow_o   ( overflow1_o  ),
        .hilo_wdata_o ( hilo_wdata1  ),
        .mul_req_o    ( mul_req1     ),
        .mul_signed_o ( mul_signed1  ),
        .div_req_o    ( div_req1     ),
        .div_signed_o ( div_signed1  ),
        .mul_result_i ( mul_result   ),
        .div_result_i ( div_result   )
    );

    alu_lane u_lane_b (
        .clk          ( clk          ),
        .reset_i      ( reset_i      ),
        .aluop_i      ( aluop2_i     ),
        .a_i          ( a2_i         ),
        .b_i          ( b2_i         ),
        .hilo_i       ( hilo_q       ),
        .y_o          ( y2_o         ),
        .overflow_o   ( overflow2_o  ),
        .hilo_wdata_o ( hilo_wdata2  ),
        .mul_req_o    ( mul_req2     ),
        .mul_signed_o ( mul_signed2  ),
        .div_req_o    ( div_req2     ),
        .div_signed_o ( div_signed2  ),
        .mul_result_i ( mul_result   ),
        .div_result_i ( div_result   )
    );

    // Lane A has priority for the shared units
    assign mul_start = mul_req1 | mul_req2;
    assign mul_sign  = mul_req1 ? mul_signed1 : mul_signed2;
    assign mul_a     = mul_req1 ? a1_i : a2_i;
    assign mul_b     = mul_req1 ? b1_i : b2_i;

    assign div_start = div_req1 | div_req2;
    assign div_sign  = div_req1 ? div_signed1 : div_signed2;
    assign div_a     = div_req1 ? a1_i : a2_i;
    assign div_b     = div_req1 ? b1_i : b2_i;

    mul_unit u_mul (
        .clk      ( clk        ),
        .reset_i  ( reset_i    ),
        .start_i  ( mul_start  ),
        .signed_i ( mul_sign   ),
        .a_i      ( mul_a      ),
        .b_i      ( mul_b      ),
        .result_o ( mul_result ),
        .ready_o  ( mul_ready  )
    );

    div_unit u_div (
        .clk      ( clk        ),
        .reset_i  ( reset_i    ),
        .start_i  ( div_start  ),
        .signed_i ( div_sign   ),
        .a_i      ( div_a      ),
        .b_i      ( div_b      ),
        .result_o ( div_result ),
        .ready_o  ( div_ready  )
    );

    assign alu_stall_o = (mul_start & ~mul_ready) | (div_start & ~div_ready);

    // Older lane A exception also kills lane B
    assign hilo_wen = ((hilo_write2_i & ~exp1_i & ~exp2_i) | (hilo_write1_i & ~exp1_i))
                      & m_ena_i & ~m_flush_i;
    assign hilo_wdata = (hilo_write2_i & ~exp2_i) ? hilo_wdata2 : hilo_wdata1;

    always_ff @(posedge clk) begin
        if (reset_i)
            hilo_q <= '0;
        else if (hilo_wen)
            hilo_q <= hilo_wdata;
    end

    a_one_issue: assert property (@(posedge clk) disable iff (reset_i)
        !(mul_req1 && mul_req2) && !(div_req1 && div_req2))
        else $error("both lanes request the same unit");

endmodule

`default_nettype wire

/* hdl/div_unit.sv */
`default_nettype none
`timescale 1ns/10ps

module div_unit import alu_pkg::*; (
    input  logic   clk,
    input  logic   reset_i,
    input  logic   start_i,
    input  logic   signed_i,
    input  word_t  a_i,
    input  word_t  b_i,
    output dword_t result_o,
    output logic   ready_o
);

    unit_state_e state_q;
    logic [5:0]  step_q;
    word_t       a_mag, b_mag;
    word_t       divisor_q;
    word_t       quo_q;
    word_t       rem_q;
    logic        neg_quo_q, neg_rem_q;
    logic [32:0] shifted, diff;
    logic        fits;
    logic        accept, last_step;
    dword_t      result_q;

    assign accept    = (state_q == unit_idle) && start_i;
    assign last_step = (step_q == 6'(div_latency - 2));

    assign a_mag = (signed_i && a_i[31]) ? -a_i : a_i;
    assign b_mag = (signed_i && b_i[31]) ? -b_i : b_i;

    assign shifted = {rem_q, quo_q[31]};
    assign diff    = shifted - {1'b0, divisor_q};
    assign fits    = ~diff[32];                 // No borrow means the divisor goes in

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= unit_idle;
            step_q  <= '0;
        end else begin
            case (state_q)
                unit_idle: if (start_i) begin
                    state_q <= unit_busy;
                    step_q  <= '0;
                end
                unit_busy: begin
                    if (last_step)
                        state_q <= unit_done;
                    else
                        step_q <= step_q + 6'd1;
                end
                default: state_q <= unit_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rem_q     <= '0;
            quo_q     <= a_mag;
            divisor_q <= b_mag;
            neg_quo_q <= signed_i & (a_i[31] ^ b_i[31]);
            neg_rem_q <= signed_i & a_i[31];    // Remainder follows the dividend
        end else if (state_q == unit_busy && !last_step) begin
            rem_q <= fits ? diff[31:0] : shifted[31:0];
            quo_q <= {quo_q[30:0], fits};
        end
        if (state_q == unit_busy && last_step) begin
            result_q[63:32] <= neg_rem_q ? -rem_q : rem_q;
            result_q[31:0]  <= neg_quo_q ? -quo_q : quo_q;
        end
    end

    assign result_o = result_q;
    assign ready_o  = (state_q == unit_done);

    a_no_div_zero: assert property (@(posedge clk) disable iff (reset_i)
        accept |-> (b_i != '0))
        else $error("divide started with zero divisor");

endmodule

`default_nettype wire

/* hdl/mul_unit.sv */
`default_nettype none
`timescale 1ns/10ps

module mul_unit import alu_pkg::*; (
    input  logic   clk,
    input  logic   reset_i,
    input  logic   start_i,
    input  logic   signed_i,
    input  word_t  a_i,
    input  word_t  b_i,
    output dword_t result_o,
    output logic   ready_o
);

    unit_state_e        state_q;
    logic [1:0]         step_q;
    logic signed [32:0] a_q, b_q;               // Sign-extended operands
    logic signed [16:0] b_lo, b_hi;
    logic signed [49:0] pp_lo_q, pp_hi_q;
    logic [65:0]        sum;
    dword_t             result_q;

    assign b_lo = {1'b0, b_q[15:0]};
    assign b_hi = b_q[32:16];
    assign sum  = {{16{pp_lo_q[49]}}, pp_lo_q} + {pp_hi_q, 16'b0};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= unit_idle;
            step_q  <= '0;
        end else begin
            case (state_q)
                unit_idle: if (start_i) begin
                    state_q <= unit_busy;
                    step_q  <= '0;
                end
                unit_busy: begin
                    step_q <= step_q + 2'd1;
                    if (step_q == 2'(mul_latency - 2))
                        state_q <= unit_done;
                end
                default: state_q <= unit_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == unit_idle && start_i) begin
            a_q <= {signed_i & a_i[31], a_i};
            b_q <= {signed_i & b_i[31], b_i};
        end
        pp_lo_q <= a_q * b_lo;                  // Halves of the 33x33 product
        pp_hi_q <= a_q * b_hi;
        if (state_q == unit_busy && step_q == 2'(mul_latency - 2))
            result_q <= sum[63:0];
    end

    assign result_o = result_q;
    assign ready_o  = (state_q == unit_done);

    a_ready_pulse: assert property (@(posedge clk) disable iff (reset_i)
        ready_o |=> !ready_o)
        else $error("mul ready held for more than one cycle");

endmodule

`default_nettype wire

/* hdl/alu_lane.sv */
`default_nettype none
`timescale 1ns/10ps

module alu_lane import alu_pkg::*; (
    input  logic    clk,
    input  logic    reset_i,

    input  alu_op_e aluop_i,
    input  word_t   a_i,
    input  word_t   b_i,
    input  dword_t  hilo_i,

    output word_t   y_o,
    output logic    overflow_o,
    output dword_t  hilo_wdata_o,

    output logic    mul_req_o,
    output logic    mul_signed_o,
    output logic    div_req_o,
    output logic    div_signed_o,

    input  dword_t  mul_result_i,
    input  dword_t  div_result_i
);

    logic [32:0] sum33;
    logic [32:0] diff33;
    logic [4:0]  shamt;

    assign sum33  = {a_i[31], a_i} + {b_i[31], b_i};   // Sign-extended for overflow
    assign diff33 = {a_i[31], a_i} - {b_i[31], b_i};
    assign shamt  = b_i[4:0];

    always_comb begin
        y_o        = '0;
        overflow_o = 1'b0;
        case (aluop_i)
            alu_add: begin
                y_o        = sum33[31:0];
                overflow_o = sum33[32] ^ sum33[31];
            end
            alu_addu: y_o = sum33[31:0];
            alu_sub: begin
                y_o        = diff33[31:0];
                overflow_o = diff33[32] ^ diff33[31];
            end
            alu_subu: y_o = diff33[31:0];
            alu_and:  y_o = a_i & b_i;
            alu_or:   y_o = a_i | b_i;
            alu_xor:  y_o = a_i ^ b_i;
            alu_nor:  y_o = ~(a_i | b_i);
            alu_slt:  y_o = {31'b0, $signed(a_i) < $signed(b_i)};
            alu_sltu: y_o = {31'b0, a_i < b_i};
            alu_sll:  y_o = a_i << shamt;
            alu_srl:  y_o = a_i >> shamt;
            alu_sra:  y_o = word_t'($signed(a_i) >>> shamt);
            alu_lui:  y_o = {b_i[15:0], 16'b0};
            alu_mfhi: y_o = hilo_i[63:32];
            alu_mflo: y_o = hilo_i[31:0];
            default:  y_o = '0;                 // mult/div and mthi/mtlo give no word
        endcase
    end

    // Value this op wants in HI/LO; the top decides whether it lands
    always_comb begin
        case (aluop_i)
            alu_mthi:             hilo_wdata_o = {a_i, hilo_i[31:0]};
            alu_mtlo:             hilo_wdata_o = {hilo_i[63:32], a_i};
            alu_mult, alu_multu:  hilo_wdata_o = mul_result_i;
            alu_div, alu_divu:    hilo_wdata_o = div_result_i;
            default:              hilo_wdata_o = hilo_i;
        endcase
    end

    assign mul_req_o    = (aluop_i == alu_mult) || (aluop_i == alu_multu);
    assign mul_signed_o = (aluop_i == alu_mult);
    assign div_req_o    = (aluop_i == alu_div) || (aluop_i == alu_divu);
    assign div_signed_o = (aluop_i == alu_div);

    a_overflow_op: assert property (@(posedge clk) disable iff (reset_i)
        overflow_o |-> (aluop_i inside {alu_add, alu_sub}))
        else $error("overflow raised for op %h", aluop_i);

endmodule

`default_nettype wire

/* hdl/alu_pkg.sv */
`default_nettype none

package alu_pkg;

    typedef logic [31:0] word_t;                // Operand or result word
    typedef logic [63:0] dword_t;               // HI in [63:32], LO in [31:0]

    typedef enum logic [7:0] {
        alu_nop   = 8'h00,
        alu_add   = 8'h01,
        alu_addu  = 8'h02,
        alu_sub   = 8'h03,
        alu_subu  = 8'h04,
        alu_and   = 8'h05,
        alu_or    = 8'h06,
        alu_xor   = 8'h07,
        alu_nor   = 8'h08,
        alu_slt   = 8'h09,
        alu_sltu  = 8'h0a,
        alu_sll   = 8'h0b,
        alu_srl   = 8'h0c,
        alu_sra   = 8'h0d,
        alu_lui   = 8'h0e,
        alu_mfhi  = 8'h0f,
        alu_mflo  = 8'h10,
        alu_mthi  = 8'h11,
        alu_mtlo  = 8'h12,
        alu_mult  = 8'h13,
        alu_multu = 8'h14,
        alu_div   = 8'h15,
        alu_divu  = 8'h16
    } alu_op_e;

    typedef enum logic [1:0] {
        unit_idle = 2'd0,
        unit_busy = 2'd1,
        unit_done = 2'd2
    } unit_state_e;

    localparam int mul_latency = 3;             // Start sampled to ready
    localparam int div_latency = 34;            // Load, 32 steps, sign fix

endpackage

`default_nettype wire
